// ==== src/ssc_pkg.sv ====
/*
 * Shared widths, counts and packed structs for the snack shopping
 * calculator. The RTL stages and the testbench import this package
 * so that the order and result layouts are defined in one place.
 */

`default_nettype none

package ssc_pkg;

    // ======================================================================
    // sizes
    // ======================================================================

    // card length in bcd digits
    localparam int unsigned N_DIGITS = 16;
    // snack kinds per order
    localparam int unsigned N_ITEMS  = 8;
    // money and change width
    localparam int unsigned MONEY_W  = 9;
    // one item cost, 15 x 15 at most
    localparam int unsigned COST_W   = 8;
    // running total plus a borrow bit
    localparam int unsigned SUM_W    = 12;

    // ======================================================================
    // types
    // ======================================================================

    typedef logic [3:0] digit_t;

    // digit 0 sits in bits 3:0
    typedef digit_t [N_DIGITS-1:0] card_t;

    typedef logic [MONEY_W-1:0] money_t;

    typedef logic [COST_W-1:0] cost_t;

    // entry N_ITEMS-1 is the top slot
    typedef cost_t [N_ITEMS-1:0] cost_vec_t;

    // one snack slot
    typedef struct packed {
        logic [3:0] count;
        logic [3:0] price;
    } item_t;

    // top level input, 137 bits
    typedef struct packed {
        card_t                   card;
        money_t                  money;
        item_t [N_ITEMS-1:0]     items;
    } order_t;

    // top level output, 10 bits
    typedef struct packed {
        logic   valid;
        money_t change;
    } result_t;

endpackage

`default_nettype wire

// ==== src/luhn_checker.sv ====
/*
 * Luhn check of a 16 digit bcd card number. Odd index digits are
 * doubled with their two digits folded back into one, all sixteen
 * values are summed and the card passes when the sum is a multiple
 * of ten. Purely combinational.
 */

`timescale 1ns/1ps
`default_nettype none

module luhn_checker
    import ssc_pkg::*;
(
    input  card_t card,
    output logic  card_ok
);

    // ======================================================================
    // digit doubling
    // ======================================================================

    // 2*d with its decimal digits added
    function automatic digit_t double_digit(input digit_t d);
        digit_t r;
        case (d)
            4'd0:    r = 4'd0;
            4'd1:    r = 4'd2;
            4'd2:    r = 4'd4;
            4'd3:    r = 4'd6;
            4'd4:    r = 4'd8;
            4'd5:    r = 4'd1;
            4'd6:    r = 4'd3;
            4'd7:    r = 4'd5;
            4'd8:    r = 4'd7;
            4'd9:    r = 4'd9;
            // non bcd nibble drops out
            default: r = 4'd0;
        endcase
        return r;
    endfunction

    logic [7:0] sum;

    // ======================================================================
    // digit sum
    // ======================================================================

    always_comb begin
        sum = 8'd0;
        for (int i = 0; i < N_DIGITS; i++) begin
            if (i % 2 == 1) begin
                sum = sum + 8'(double_digit(card[i]));
            end else begin
                // even slots pass as is, even above 9
                sum = sum + 8'(card[i]);
            end
        end
    end

    // ======================================================================
    // mod ten test
    // ======================================================================

    // bcd input keeps the sum within 0..144
    // higher multiples only come from nibbles above 9
    always_comb begin
        case (sum)
            8'd0, 8'd10, 8'd20, 8'd30, 8'd40,
            8'd50, 8'd60, 8'd70, 8'd80, 8'd90,
            8'd100, 8'd110, 8'd120, 8'd130, 8'd140,
            8'd150, 8'd160, 8'd170, 8'd180, 8'd190: begin
                card_ok = 1'b1;
            end
            default: begin
                card_ok = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/cost_sorter.sv ====
/*
 * Item cost and sort stage. Each slot's count is multiplied by its
 * unit price, and the eight costs go through a Batcher odd-even merge
 * network of nineteen compare-exchange steps. Output is ascending,
 * so entry N_ITEMS-1 holds the largest cost. Purely combinational.
 */

`timescale 1ns/1ps
`default_nettype none

module cost_sorter
    import ssc_pkg::*;
(
    input  item_t [N_ITEMS-1:0] items,
    output cost_vec_t           sorted
);

    // ======================================================================
    // compare-exchange
    // ======================================================================

    // returns {larger, smaller}
    // decision taken from the borrow of a - b
    function automatic logic [2*COST_W-1:0] cmp_swap(input cost_t a, input cost_t b);
        logic [COST_W:0] diff;
        diff = {1'b0, a} - {1'b0, b};
        if (diff[COST_W]) begin
            // a below b, keep order
            return {b, a};
        end else begin
            return {a, b};
        end
    endfunction

    cost_vec_t costs;
    cost_vec_t net;

    // ======================================================================
    // per item cost
    // ======================================================================

    always_comb begin
        for (int i = 0; i < N_ITEMS; i++) begin
            costs[i] = COST_W'(items[i].count) * COST_W'(items[i].price);
        end
    end

    // ======================================================================
    // odd-even merge network
    // ======================================================================

    always_comb begin
        net = costs;

        // sort pairs
        {net[1], net[0]} = cmp_swap(net[0], net[1]);
        {net[3], net[2]} = cmp_swap(net[2], net[3]);
        {net[5], net[4]} = cmp_swap(net[4], net[5]);
        {net[7], net[6]} = cmp_swap(net[6], net[7]);

        // merge pairs into sorted fours
        {net[2], net[0]} = cmp_swap(net[0], net[2]);
        {net[3], net[1]} = cmp_swap(net[1], net[3]);
        {net[6], net[4]} = cmp_swap(net[4], net[6]);
        {net[7], net[5]} = cmp_swap(net[5], net[7]);

        // inner fixups of each four
        {net[2], net[1]} = cmp_swap(net[1], net[2]);
        {net[6], net[5]} = cmp_swap(net[5], net[6]);

        // merge the two fours, stride four
        {net[4], net[0]} = cmp_swap(net[0], net[4]);
        {net[5], net[1]} = cmp_swap(net[1], net[5]);
        {net[6], net[2]} = cmp_swap(net[2], net[6]);
        {net[7], net[3]} = cmp_swap(net[3], net[7]);

        // stride two
        {net[4], net[2]} = cmp_swap(net[2], net[4]);
        {net[5], net[3]} = cmp_swap(net[3], net[5]);

        // final neighbour pass
        // ends 0 and 7 are already settled
        {net[2], net[1]} = cmp_swap(net[1], net[2]);
        {net[4], net[3]} = cmp_swap(net[3], net[4]);
        {net[6], net[5]} = cmp_swap(net[5], net[6]);
    end

    // smallest at 0, largest at N_ITEMS-1
    assign sorted = net;

endmodule

`default_nettype wire

// ==== src/change_calc.sv ====
/*
 * Greedy purchase and output register. Running totals of the largest
 * costs are subtracted from the money, and the borrow bits pick the
 * last total that still fits. The change and valid flag are
 * registered, so the result follows its order by one clock. A
 * rejected card returns the money untouched with valid low.
 */

`timescale 1ns/1ps
`default_nettype none

module change_calc
    import ssc_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  cost_vec_t sorted,
    input  logic      card_ok,
    input  money_t    money,
    output result_t   result
);

    // total[k] holds the k+1 largest costs
    logic [SUM_W-1:0]   total [N_ITEMS];
    // money minus total[k], msb is the borrow
    logic [SUM_W-1:0]   diff [N_ITEMS];
    logic [N_ITEMS-1:0] borrow;
    money_t             fit_change;

    // ======================================================================
    // running totals, largest first
    // ======================================================================

    always_comb begin
        total[0] = SUM_W'(sorted[N_ITEMS-1]);
        for (int k = 1; k < N_ITEMS; k++) begin
            total[k] = total[k-1] + SUM_W'(sorted[N_ITEMS-1-k]);
        end
    end

    always_comb begin
        for (int k = 0; k < N_ITEMS; k++) begin
            diff[k]   = SUM_W'(money) - total[k];
            borrow[k] = diff[k][SUM_W-1];
        end
    end

    // ======================================================================
    // purchase select
    // ======================================================================

    // first borrow stops the buying
    // later cheaper items are skipped even if they would fit
    always_comb begin
        logic stopped;
        stopped    = 1'b0;
        // nothing bought yet
        fit_change = money;
        for (int k = 0; k < N_ITEMS; k++) begin
            if (!stopped) begin
                if (borrow[k]) begin
                    stopped = 1'b1;
                end else begin
                    // no borrow, so the difference fits in MONEY_W
                    fit_change = diff[k][MONEY_W-1:0];
                end
            end
        end
    end

    // ======================================================================
    // output register
    // ======================================================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
        end else begin
            result.valid  <= card_ok;
            // rejected card gets its money back
            result.change <= card_ok ? fit_change : money;
        end
    end

endmodule

`default_nettype wire

// ==== src/ssc_top.sv ====
/*
 * Top level of the snack shopping calculator. The order is a level
 * input sampled every clock; the card check and the cost sort are
 * combinational and the change stage registers the result, giving a
 * latency of one cycle with a new order accepted every cycle.
 */

`timescale 1ns/1ps
`default_nettype none

module ssc_top
    import ssc_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  order_t  order,
    output result_t result
);

    // luhn result for the current order
    logic      card_ok;
    // costs in ascending order
    cost_vec_t sorted;

    // ======================================================================
    // stages
    // ======================================================================

    // card check
    luhn_checker luhn_checker_inst (
        .card    (order.card),
        .card_ok (card_ok)
    );

    // cost and sort
    cost_sorter cost_sorter_inst (
        .items  (order.items),
        .sorted (sorted)
    );

    // greedy change, registered
    change_calc change_calc_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .sorted  (sorted),
        .card_ok (card_ok),
        .money   (order.money),
        .result  (result)
    );

endmodule

`default_nettype wire

// ==== sim/tb_ssc.sv ====
/*
 * Directed testbench for the snack shopping calculator. Orders are
 * driven on the falling clock edge and results are checked one cycle
 * later against a reference model of the Luhn and greedy change rules.
 * Covers reset, card checks, greedy stops, slot permutations and a
 * random back-to-back stream.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_ssc
    import ssc_pkg::*;
();

    localparam int          CLK_PERIOD    = 8;
    localparam int          RESET_CYCLES  = 4;
    localparam int          WAIT_LIMIT    = 20;
    localparam int          STREAM_CYCLES = 200;
    localparam logic [63:0] VALID_CARD    = 64'h4111_1111_1111_1111;

    logic    clk;
    logic    arst_n;
    order_t  order;
    result_t result;

    integer seed;
    int     cycle_count = 0;
    int     check_count = 0;
    int     error_count = 0;
    int     test_count  = 0;

    ssc_top ssc_top_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .order  (order),
        .result (result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // rising edges seen so far
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
    end

    // ======================================================================
    // reference model
    // ======================================================================

    // odd slots doubled and folded, nibbles above 9 drop out there
    function automatic int luhn_sum(input card_t c);
        int s;
        int d;
        s = 0;
        for (int i = 0; i < N_DIGITS; i++) begin
            d = int'(c[i]);
            if (i % 2 == 0) begin
                s = s + d;
            end else if (d <= 9) begin
                d = 2 * d;
                if (d > 9) begin
                    d = d / 10 + d % 10;
                end
                s = s + d;
            end
        end
        return s;
    endfunction

    function automatic result_t make_result(input logic v, input money_t c);
        result_t r;
        r.valid  = v;
        r.change = c;
        return r;
    endfunction

    // buy from the most expensive down, stop at the first misfit
    function automatic result_t expected_result(input order_t o);
        int   cost [N_ITEMS];
        int   tmp;
        int   spent;
        int   money;
        logic stopped;
        logic ok;
        for (int i = 0; i < N_ITEMS; i++) begin
            cost[i] = int'(o.items[i].count) * int'(o.items[i].price);
        end
        for (int i = 0; i < N_ITEMS - 1; i++) begin
            for (int j = 0; j < N_ITEMS - 1 - i; j++) begin
                if (cost[j] < cost[j+1]) begin
                    tmp       = cost[j];
                    cost[j]   = cost[j+1];
                    cost[j+1] = tmp;
                end
            end
        end
        money   = int'(o.money);
        spent   = 0;
        stopped = 1'b0;
        for (int k = 0; k < N_ITEMS; k++) begin
            if (!stopped && spent + cost[k] > money) begin
                stopped = 1'b1;
            end else if (!stopped) begin
                spent = spent + cost[k];
            end
        end
        ok = (luhn_sum(o.card) % 10 == 0);
        return make_result(ok, ok ? money_t'(money - spent) : o.money);
    endfunction

    function automatic order_t make_order(input card_t c, input money_t m,
                                          input logic [8*N_ITEMS-1:0] items);
        order_t o;
        o.card  = c;
        o.money = m;
        o.items = items;
        return o;
    endfunction

    // mostly bcd digits, about half the cards fixed up to pass
    function automatic order_t random_order();
        order_t o;
        int     s;
        for (int i = 0; i < N_DIGITS; i++) begin
            o.card[i] = digit_t'($unsigned($random(seed)) % 10);
            if (($random(seed) & 15) == 0) begin
                o.card[i] = digit_t'($random(seed));
            end
        end
        if ($random(seed) & 1) begin
            o.card[0] = 4'd0;
            s         = luhn_sum(o.card);
            o.card[0] = digit_t'((10 - s % 10) % 10);
        end
        o.money = money_t'($random(seed));
        o.items = {$random(seed), $random(seed)};
        return o;
    endfunction

    // ======================================================================
    // compare and wait helpers
    // ======================================================================

    task automatic check_result(input string name, input result_t exp, input result_t act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            $display("MISMATCH %s: expected valid=%0b change=%0d, actual valid=%0b change=%0d",
                     name, exp.valid, exp.change, act.valid, act.change);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            $display("MISMATCH %s: expected %0b, actual %0b", name, exp, act);
        end
    endtask

    // returns on a falling edge, n rising edges later
    task automatic wait_cycles(input int n);
        int target;
        int guard;
        target = cycle_count + n;
        guard  = 0;
        while (cycle_count < target && guard < WAIT_LIMIT) begin
            @(negedge clk);
            guard++;
        end
        if (cycle_count < target) begin
            $display("ERROR: clock stopped, %0d edges missing", target - cycle_count);
            $display("TESTBENCH FAILED");
            $finish;
        end
    endtask

    // drive at a falling edge, check one cycle later
    task automatic run_order(input string name, input order_t o);
        order = o;
        wait_cycles(1);
        check_result(name, expected_result(o), result);
    endtask

    task automatic report_test(input string name, input int start_errors);
        test_count++;
        $display("test %-14s %s (%0d errors)", name,
                 (error_count == start_errors) ? "pass" : "fail", error_count - start_errors);
    endtask

    // ======================================================================
    // tests
    // ======================================================================

    task automatic reset_behavior();
        int start;
        start = error_count;
        // valid card with money, a register left out of reset would show it
        order = make_order(VALID_CARD, 9'd100, 64'h11_22_33_44_55_66_77_88);
        for (int i = 0; i < RESET_CYCLES; i++) begin
            wait_cycles(1);
            check_result("reset held", make_result(1'b0, 9'd0), result);
        end
        arst_n = 1'b1;
        check_result("reset release", make_result(1'b0, 9'd0), result);
        // invalid card and no money, so the first real result is zero too
        order = make_order(64'h1, 9'd0, 64'h11_22_33_44_55_66_77_88);
        wait_cycles(1);
        check_result("first edge", make_result(1'b0, 9'd0), result);
        report_test("reset", start);
    endtask

    task automatic card_validation();
        card_t cards [10];
        logic  hand  [10];
        int    start;
        start = error_count;
        cards[0] = VALID_CARD;
        hand[0]  = 1'b1;
        cards[1] = 64'h4111_1111_1111_1112;
        hand[1]  = 1'b0;
        // sum 32, even but not a multiple of ten
        cards[2] = 64'h4111_1111_1111_1113;
        hand[2]  = 1'b0;
        cards[3] = 64'h0;
        hand[3]  = 1'b1;
        // doubled 5 folds to 1
        cards[4] = 64'h59;
        hand[4]  = 1'b1;
        cards[5] = 64'h58;
        hand[5]  = 1'b0;
        cards[6] = 64'h4111_1111_1111_11a1;
        hand[6]  = 1'b0;
        cards[7] = 64'h4111_1111_1111_111a;
        hand[7]  = 1'b0;
        // non bcd nibble passes in an even slot
        cards[8] = 64'ha;
        hand[8]  = 1'b1;
        cards[9] = 64'ha0;
        hand[9]  = 1'b1;
        for (int i = 0; i < 10; i++) begin
            run_order($sformatf("card %0d", i),
                      make_order(cards[i], 9'd150, 64'h23_45_11_00_00_00_00_00));
            check_bit($sformatf("card %0d valid", i), hand[i], result.valid);
        end
        report_test("card check", start);
    endtask

    task automatic greedy_stops();
        int start;
        start = error_count;
        // costs 1, 4, 9 all fit
        run_order("all fit", make_order(VALID_CARD, 9'd100, 64'h11_22_33_00_00_00_00_00));
        check_result("all fit hand", make_result(1'b1, 9'd86), result);
        // 225 above 200
        run_order("none fit", make_order(VALID_CARD, 9'd200, 64'hff_11_00_00_00_00_00_00));
        check_result("none fit hand", make_result(1'b1, 9'd200), result);
        // 9 + 4 lands exactly on the money
        run_order("equality", make_order(VALID_CARD, 9'd13, 64'h11_22_33_00_00_00_00_00));
        check_result("equality hand", make_result(1'b1, 9'd0), result);
        // 5 misses, so the cost 1 item is skipped
        run_order("skip later", make_order(VALID_CARD, 9'd10, 64'h33_15_11_00_00_00_00_00));
        check_result("skip later hand", make_result(1'b1, 9'd1), result);
        run_order("max costs", make_order(VALID_CARD, 9'd511, {N_ITEMS{8'hff}}));
        check_result("max costs hand", make_result(1'b1, 9'd61), result);
        report_test("greedy", start);
    endtask

    task automatic slot_permutations();
        item_t [N_ITEMS-1:0] base;
        int                  idx [N_ITEMS];
        int                  j;
        int                  tmp;
        order_t              o;
        int                  start;
        start = error_count;
        // costs 36 30 28 27 26 25 1 0, 120 buys the top three
        base  = 64'h47_39_f2_11_05_66_2d_55;
        for (int p = 0; p < 8; p++) begin
            for (int i = 0; i < N_ITEMS; i++) begin
                case (p)
                    0:       idx[i] = i;
                    1:       idx[i] = N_ITEMS - 1 - i;
                    2:       idx[i] = (i + 3) % N_ITEMS;
                    default: idx[i] = i;
                endcase
            end
            // shuffle for the remaining permutations
            if (p > 2) begin
                for (int i = N_ITEMS - 1; i > 0; i--) begin
                    j      = $unsigned($random(seed)) % (i + 1);
                    tmp    = idx[i];
                    idx[i] = idx[j];
                    idx[j] = tmp;
                end
            end
            o = make_order(VALID_CARD, 9'd120, 64'h0);
            for (int i = 0; i < N_ITEMS; i++) begin
                o.items[i] = base[idx[i]];
            end
            run_order($sformatf("perm %0d", p), o);
            // same hand value for every slot order
            check_result($sformatf("perm %0d hand", p), make_result(1'b1, 9'd26), result);
        end
        report_test("permutations", start);
    endtask

    task automatic back_to_back_stream();
        order_t  o;
        result_t prev_exp;
        int      start;
        start = error_count;
        for (int i = 0; i < STREAM_CYCLES; i++) begin
            if (i > 0) begin
                check_result($sformatf("stream %0d", i - 1), prev_exp, result);
            end
            o        = random_order();
            order    = o;
            prev_exp = expected_result(o);
            wait_cycles(1);
        end
        check_result($sformatf("stream %0d", STREAM_CYCLES - 1), prev_exp, result);
        report_test("back to back", start);
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================

    initial begin
        seed   = 32'hb22e_d9f9;
        arst_n = 1'b0;
        order  = '0;

        reset_behavior();
        card_validation();
        greedy_stops();
        slot_permutations();
        back_to_back_stream();

        $display("summary: %0d tests, %0d checks, %0d errors",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
src/ssc_pkg.sv
src/luhn_checker.sv
src/cost_sorter.sv
src/change_calc.sv
src/ssc_top.sv
sim/tb_ssc.sv
